// File: tests/pipe_trace.txt
# T <test name> <retReady stall percent, decimal>
# I <op> <rd> <rs1> <rs2> <imm> <expected retValue> <expected retWrite>, all in hex
# op: 0 add, 1 sub, 2 and, 3 xor, 4 shl, 5 loadImm, 6 load, 7 store
T alu 0
I 5 1 0 0 0003 0003 1
I 5 2 0 0 0005 0005 1
I 5 3 0 0 00f0 00f0 1
I 5 4 0 0 0ff0 0ff0 1
I 0 5 1 2 0000 0008 1
I 1 6 3 4 0000 f100 1
I 2 7 3 4 0000 00f0 1
I 3 8 3 4 0000 0f00 1
I 4 9 1 2 0000 0060 1
I 4 a 4 3 0000 0ff0 1
T forward 0
I 5 1 0 0 0010 0010 1
I 0 2 1 1 0000 0020 1
I 0 3 2 1 0000 0030 1
I 1 4 3 2 0000 0010 1
I 5 5 0 0 0001 0001 1
I 5 5 0 0 0002 0002 1
I 0 6 5 5 0000 0004 1
I 3 7 6 5 0000 0006 1
I 5 0 0 0 1234 1234 0
I 0 8 0 1 0000 0010 1
I 0 0 1 1 0000 0020 0
I 0 9 0 0 0000 0000 1
T loadUse 0
I 5 1 0 0 0040 0040 1
I 5 2 0 0 abcd abcd 1
I 7 0 1 2 0002 abcd 0
I 6 3 1 0 0002 abcd 1
I 0 4 3 1 0000 ac0d 1
I 6 5 1 0 0002 abcd 1
I 1 6 1 5 0000 5473 1
T memForward 0
I 5 7 0 0 1357 1357 1
I 7 0 1 7 0005 1357 0
I 6 8 1 0 0005 1357 1
I 7 0 1 8 0006 1357 0
I 6 9 1 0 0006 1357 1
T backPressure 40
I 5 1 0 0 0007 0007 1
I 5 2 0 0 0003 0003 1
I 0 3 1 2 0000 000a 1
I 4 4 3 2 0000 0050 1
I 1 5 4 1 0000 0049 1
I 7 0 0 5 0010 0049 0
I 6 6 0 0 0010 0049 1
I 3 7 6 3 0000 0043 1
I 2 8 7 4 0000 0040 1
I 5 0 0 0 ffff ffff 0
I 0 9 8 0 0000 0040 1
I 7 0 0 9 0011 0040 0
I 6 a 0 0 0011 0040 1
I 0 b a a 0000 0080 1

// File: all.f
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/ForwardingUnit.sv
source/IssueStage.sv
source/ExecuteStage.sv
source/MemoryStage.sv
source/WritebackStage.sv
source/PipeCore.sv
tests/PipeCore_properties.sv
tests/PipeCore_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the PipeCore testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module PipeCore_tb -f all.f -o PipeCore_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/PipeCore_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tests/PipeCore_tb.sv
`timescale 1ns/1ns

module PipeCore_tb import isaPkg::*; ();

  logic    clk;
  logic    arstN;
  logic    inValid;
  logic    inReady;
  opcode_t inOp;
  regIdx_t inRd;
  regIdx_t inRs1;
  regIdx_t inRs2;
  word_t   inImm;
  logic    retValid;
  logic    retReady;
  opcode_t retOp;
  regIdx_t retRd;
  word_t   retValue;
  logic    retWrite;

  // One entry per instruction and its expected retirement at the same index
  string   nameQ[$];
  int      pctQ[$];     // Chance in percent that retReady is low for this retirement
  opcode_t opQ[$];
  regIdx_t rdQ[$];
  regIdx_t rs1Q[$];
  regIdx_t rs2Q[$];
  word_t   immQ[$];
  word_t   valueQ[$];
  logic    writeQ[$];
  int      traceLines;    // Sizes the watchdog
  int      stallCycles;   // Cycles with retReady low that extend the watchdog limit
  int      checksFailed;
  int      seed;

  PipeCore i_dut (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady), .inOp(inOp),
    .inRd(inRd), .inRs1(inRs1), .inRs2(inRs2), .inImm(inImm),
    .retValid(retValid), .retReady(retReady), .retOp(retOp), .retRd(retRd),
    .retValue(retValue), .retWrite(retWrite)
  );

  //////////////////////////////////////////////////////////////////////
  // Error handling and result checks
  //////////////////////////////////////////////////////////////////////
  task automatic stopWithFailure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkRetire(input string testName, input opcode_t expOp,
                             input regIdx_t expRd, input word_t expValue);
    if (retOp !== expOp) begin
      checksFailed++;
      $display("mismatch %s retOp expected %s actual %s", testName, expOp.name(), retOp.name());
      stopWithFailure("wrong opcode at the retire port");
    end
    if (retRd !== expRd) begin
      checksFailed++;
      $display("mismatch %s retRd expected %0d actual %0d", testName, expRd, retRd);
      stopWithFailure("wrong destination register at the retire port");
    end
    if (retValue !== expValue) begin
      checksFailed++;
      $display("mismatch %s retValue expected %h actual %h", testName, expValue, retValue);
      stopWithFailure("wrong result value at the retire port");
    end
  endtask

  task automatic checkWrite(input string testName, input logic expWrite);
    if (retWrite !== expWrite) begin
      checksFailed++;
      $display("mismatch %s retWrite expected %b actual %b", testName, expWrite, retWrite);
      stopWithFailure("wrong register write flag at the retire port");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace reader
  //////////////////////////////////////////////////////////////////////
  task automatic readTrace();
    int    fd;
    int    n;
    int    pct;
    int    op;
    int    rd;
    int    rs1;
    int    rs2;
    int    imm;
    int    value;
    int    wr;
    string line;
    string testName;
    fd = $fopen("tests/pipe_trace.txt", "r");
    if (fd == 0) begin
      stopWithFailure("could not open the trace file tests/pipe_trace.txt");
    end
    testName = "none";
    pct = 0;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;  // Blank or comment line
      end
      if (line.getc(0) == "T") begin
        n = $sscanf(line, "T %s %d", testName, pct);  // New test name and stall rate
        if (n != 2) stopWithFailure("a test line in the trace is malformed");
      end else if (line.getc(0) == "I") begin
        n = $sscanf(line, "I %h %h %h %h %h %h %h", op, rd, rs1, rs2, imm, value, wr);
        if (n != 7) stopWithFailure("an instruction line in the trace is malformed");
        nameQ.push_back(testName);
        pctQ.push_back(pct);
        opQ.push_back(opcode_t'(op[2:0]));
        rdQ.push_back(regIdx_t'(rd));
        rs1Q.push_back(regIdx_t'(rs1));
        rs2Q.push_back(regIdx_t'(rs2));
        immQ.push_back(word_t'(imm));
        valueQ.push_back(word_t'(value));
        writeQ.push_back(wr[0]);
      end else begin
        stopWithFailure("the trace holds a line of unknown kind");
      end
      traceLines++;
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and retire collection
  //////////////////////////////////////////////////////////////////////
  function automatic logic drawStall(input int pct);
    int draw;
    draw = $random(seed) & 32'h7fffffff;
    return (draw % 100) < pct;
  endfunction

  // Inputs change on the falling edge and handshakes are sampled 1 ns before the rising edge
  task automatic feedInstructions();
    int idx;
    idx = 0;
    while (idx < opQ.size()) begin
      @(negedge clk);
      inValid = 1'b1;
      inOp    = opQ[idx];
      inRd    = rdQ[idx];
      inRs1   = rs1Q[idx];
      inRs2   = rs2Q[idx];
      inImm   = immQ[idx];
      #4;
      if (inReady) idx++;  // Transfer on the coming edge or the fields stay as they are
    end
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic collectRetires();
    int idx;
    idx = 0;
    while (idx < opQ.size()) begin
      @(negedge clk);
      retReady = !drawStall(pctQ[idx]);
      if (!retReady) stallCycles++;
      #4;
      if (retValid && retReady) begin
        checkRetire(nameQ[idx], opQ[idx], rdQ[idx], valueQ[idx]);
        checkWrite(nameQ[idx], writeQ[idx]);
        idx++;
      end
    end
    @(negedge clk);
    retReady = 1'b1;
  endtask

  // Nothing may come out once every traced instruction has retired
  task automatic checkDrained();
    repeat (6) begin
      @(negedge clk);
      #4;
      if (retValid) stopWithFailure("an extra instruction retired after the trace was done");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, main flow and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : mainFlow
    seed         = 32'hc6f27614;
    traceLines   = 0;
    stallCycles  = 0;
    checksFailed = 0;
    arstN        = 1'b0;
    inValid      = 1'b0;
    inOp         = opAdd;
    inRd         = '0;
    inRs1        = '0;
    inRs2        = '0;
    inImm        = '0;
    retReady     = 1'b1;
    readTrace();
    repeat (4) @(posedge clk);  // Reset over 4 cycles
    @(negedge clk);
    arstN = 1'b1;
    #4;
    // The input stays closed for the first cycle out of reset
    if (inReady !== 1'b0) stopWithFailure("inReady was high in the first cycle after reset");
    fork
      feedInstructions();
      collectRetires();
    join
    checkDrained();
    if (checksFailed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 20 * traceLines + stallCycles) begin  // Limit grows with every stall
        stopWithFailure("timeout, the pipeline stopped retiring instructions");
      end
    end
  end

endmodule

// File: tests/PipeCore_properties.sv
`timescale 1ns/1ns

module PipeCore_properties import isaPkg::*, pipePkg::*; (
  input logic    clk,
  input logic    arstN,
  input logic    inValid,
  input logic    inReady,
  input opcode_t inOp,
  input regIdx_t inRs1,
  input regIdx_t inRs2,
  input logic    exValid,
  input opcode_t exOp,
  input regIdx_t exRd,
  input regIdx_t memRd,
  input fwdSel_t forwardA,
  input logic    retValid,
  input logic    retReady,
  input opcode_t retOp,
  input regIdx_t retRd,
  input word_t   retValue,
  input logic    retWrite
);

  logic loadHazard;  // Waiting instruction needs the load now in execute
  logic moving;      // The pipeline steps on this edge

  // A store reads rs2 late, so only its rs1 counts
  assign loadHazard = inValid && exValid && (exOp == opLoad) && (exRd != '0) &&
                      ((inRs1 == exRd) || ((inOp != opStore) && (inRs2 == exRd)));

  // Only a stalled retirement freezes the pipe
  assign moving = !retValid || retReady;

  //////////////////////////////////////////////////////////////////////
  // Handshake and forwarding rules
  //////////////////////////////////////////////////////////////////////
  retireHeld: assert property (@(posedge clk) disable iff (!arstN)
    retValid && !retReady |=> retValid && $stable(retOp) && $stable(retRd) &&
                              $stable(retValue) && $stable(retWrite))
    else $error("retire fields changed while the consumer stalled");

  // The input is closed when the hazard is seen and a bubble enters execute
  holdClosesInput: assert property (@(posedge clk) disable iff (!arstN)
    loadHazard && moving |=> !$past(inReady) && !exValid)
    else $error("no bubble went into execute for a load-use hold");

  noMemForwardFromZero: assert property (@(posedge clk) disable iff (!arstN)
    (forwardA == fwdFromMem) |-> (memRd != '0))
    else $error("operand A forwarded from memory for register 0");

endmodule

bind PipeCore PipeCore_properties i_props (
  .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady), .inOp(inOp),
  .inRs1(inRs1), .inRs2(inRs2), .exValid(exValid), .exOp(exOp), .exRd(exRd),
  .memRd(memRd), .forwardA(forwardA), .retValid(retValid), .retReady(retReady),
  .retOp(retOp), .retRd(retRd), .retValue(retValue), .retWrite(retWrite)
);

// File: source/PipeCore.sv
`timescale 1ns/1ns
`default_nettype none

module PipeCore import isaPkg::*, pipePkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    inValid,   // Decoded instruction handshake
  output logic    inReady,
  input  opcode_t inOp,
  input  regIdx_t inRd,
  input  regIdx_t inRs1,
  input  regIdx_t inRs2,
  input  word_t   inImm,
  output logic    retValid,  // Retire handshake, in program order
  input  logic    retReady,
  output opcode_t retOp,
  output regIdx_t retRd,
  output word_t   retValue,
  output logic    retWrite
);

  logic    advance;  // Every pipeline register moves together on this
  logic    exValid;
  opcode_t exOp;
  regIdx_t exRd;
  regIdx_t exRs1;
  regIdx_t exRs2;
  word_t   exImm;
  word_t   exA;
  word_t   exB;
  fwdSel_t forwardA;
  fwdSel_t forwardB;
  logic    forwardMem;
  logic    memValid;
  opcode_t memOp;
  regIdx_t memRd;
  regIdx_t memSrcReg2;
  word_t   memAluValue;
  word_t   memStoreData;
  logic    memRegWrite;
  logic    wbValid;
  opcode_t wbOp;
  regIdx_t wbRd;
  word_t   wbValue;
  logic    wbRegWrite;
  logic    rfWe;
  regIdx_t rfAddr;
  word_t   rfData;

  // Back-pressure at the retire port freezes the whole pipe
  assign advance = !retValid || retReady;

  ////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////
  IssueStage i_issue (
    .clk, .arstN, .advance, .inValid, .inOp, .inRd, .inRs1, .inRs2, .inImm,
    .rfWe, .rfAddr, .rfData, .inReady,
    .exValid, .exOp, .exRd, .exRs1, .exRs2, .exImm, .exA, .exB
  );

  ForwardingUnit i_forward (
    .exSrcReg1(exRs1), .exSrcReg2(exRs2), .memSrcReg2,
    .memDestReg(memRd), .wbDestReg(wbRd), .memRegWrite, .wbRegWrite,
    .forwardA, .forwardB, .forwardMem
  );

  ExecuteStage i_execute (
    .clk, .arstN, .advance, .exValid, .exOp, .exRd, .exRs2, .exImm, .exA, .exB,
    .forwardA, .forwardB, .wbValue,
    .memValid, .memOp, .memRd, .memSrcReg2, .memAluValue, .memStoreData, .memRegWrite
  );

  MemoryStage i_memory (
    .clk, .arstN, .advance, .memValid, .memOp, .memRd, .memAluValue,
    .memStoreData, .memRegWrite, .forwardMem,
    .wbValid, .wbOp, .wbRd, .wbValue, .wbRegWrite
  );

  WritebackStage i_writeback (
    .wbValid, .wbOp, .wbRd, .wbValue, .wbRegWrite, .retReady,
    .retValid, .retOp, .retRd, .retValue, .retWrite, .rfWe, .rfAddr, .rfData
  );

endmodule

`default_nettype wire

// File: source/WritebackStage.sv
`timescale 1ns/1ns
`default_nettype none

module WritebackStage import isaPkg::*; (
  input  logic    wbValid,     // Writeback holds a real instruction
  input  opcode_t wbOp,
  input  regIdx_t wbRd,
  input  word_t   wbValue,
  input  logic    wbRegWrite,  // Already low for stores, rd 0 and bubbles
  input  logic    retReady,    // Consumer takes the retirement on this edge
  output logic    retValid,
  output opcode_t retOp,
  output regIdx_t retRd,
  output word_t   retValue,
  output logic    retWrite,
  output logic    rfWe,
  output regIdx_t rfAddr,
  output word_t   rfData
);

  ////////////////////////////////////////////////////////////////////
  // Retire port
  ////////////////////////////////////////////////////////////////////
  // The instruction sits here until it is taken, nothing is buffered
  assign retValid = wbValid;
  assign retOp    = wbOp;
  assign retRd    = wbRd;
  assign retValue = wbValue;   // Result for writers, stored data for opStore
  assign retWrite = wbRegWrite;

  ////////////////////////////////////////////////////////////////////
  // Register-file write port
  ////////////////////////////////////////////////////////////////////
  // The write only happens on the edge that retires the instruction
  // While the consumer stalls, the value keeps reaching execute by forwarding
  assign rfWe   = wbValid && wbRegWrite && retReady;
  assign rfAddr = wbRd;
  assign rfData = wbValue;

endmodule

`default_nettype wire

// File: source/MemoryStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_config.svh"

module MemoryStage import isaPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    advance,
  input  logic    memValid,
  input  opcode_t memOp,
  input  regIdx_t memRd,
  input  word_t   memAluValue,
  input  word_t   memStoreData,
  input  logic    memRegWrite,
  input  logic    forwardMem,   // Take the store data from writeback instead
  output logic    wbValid,
  output opcode_t wbOp,
  output regIdx_t wbRd,
  output word_t   wbValue,      // Result in writeback, also fed back for forwarding
  output logic    wbRegWrite
);

  localparam int AddrBits = $clog2(`DMEM_DEPTH);

  word_t                dataRam [`DMEM_DEPTH];
  logic  [AddrBits-1:0] ramAddr;    // Low bits of the address, upper bits ignored
  word_t                storeData;  // Store data after the memory-to-memory forward

  assign ramAddr   = memAluValue[AddrBits-1:0];
  assign storeData = forwardMem ? wbValue : memStoreData;

  ////////////////////////////////////////////////////////////////////
  // Data RAM
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (advance && memValid && (memOp == opStore)) begin
      dataRam[ramAddr] <= storeData;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Memory/writeback register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbValid    <= 1'b0;
      wbRegWrite <= 1'b0;
    end else if (advance) begin
      wbValid    <= memValid;
      wbRegWrite <= memRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      wbOp <= memOp;
      wbRd <= memRd;
      case (memOp)
        opLoad:  wbValue <= dataRam[ramAddr];  // Synchronous read lands in writeback
        opStore: wbValue <= storeData;         // Retire port reports what was stored
        default: wbValue <= memAluValue;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/ExecuteStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_config.svh"

module ExecuteStage import isaPkg::*, pipePkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    advance,
  input  logic    exValid,
  input  opcode_t exOp,
  input  regIdx_t exRd,
  input  regIdx_t exRs2,
  input  word_t   exImm,
  input  word_t   exA,
  input  word_t   exB,
  input  fwdSel_t forwardA,
  input  fwdSel_t forwardB,
  input  word_t   wbValue,       // Result in writeback, forwarded back here
  output logic    memValid,
  output opcode_t memOp,
  output regIdx_t memRd,
  output regIdx_t memSrcReg2,    // Store data source, checked for a memory forward
  output word_t   memAluValue,   // ALU result or RAM address, also forwarded
  output word_t   memStoreData,
  output logic    memRegWrite
);

  localparam int ShiftBits = $clog2(`DATA_WIDTH);

  word_t opA;        // First operand after forwarding
  word_t opB;        // Second operand after forwarding
  word_t aluResult;

  function automatic word_t pickOperand(input fwdSel_t sel, input word_t fromReg,
                                        input word_t fromMem, input word_t fromWb);
    word_t value;
    case (sel)
      fwdFromMem: value = fromMem;
      fwdFromWb:  value = fromWb;
      default:    value = fromReg;
    endcase
    return value;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////////////////////////////////
  assign opA = pickOperand(forwardA, exA, memAluValue, wbValue);
  assign opB = pickOperand(forwardB, exB, memAluValue, wbValue);

  always_comb begin
    case (exOp)
      opAdd:     aluResult = opA + opB;
      opSub:     aluResult = opA - opB;
      opAnd:     aluResult = opA & opB;
      opXor:     aluResult = opA ^ opB;
      opShl:     aluResult = opA << opB[ShiftBits-1:0];  // Only the low bits count
      opLoadImm: aluResult = exImm;
      default:   aluResult = opA + exImm;  // Address for opLoad and opStore
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Execute/memory register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memValid    <= 1'b0;
      memRegWrite <= 1'b0;
    end else if (advance) begin
      memValid    <= exValid;
      memRegWrite <= exValid && (exOp != opStore) && (exRd != '0);  // Bubbles write nothing
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      memOp        <= exOp;
      memRd        <= exRd;
      memSrcReg2   <= exRs2;
      memAluValue  <= aluResult;
      memStoreData <= opB;  // May still be replaced in memory by a load result
    end
  end

endmodule

`default_nettype wire

// File: source/IssueStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_config.svh"

module IssueStage import isaPkg::*, pipePkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    advance,  // Whole pipeline moves on this edge
  input  logic    inValid,  // Decoded instruction waiting at the input
  input  opcode_t inOp,
  input  regIdx_t inRd,
  input  regIdx_t inRs1,
  input  regIdx_t inRs2,
  input  word_t   inImm,
  input  logic    rfWe,     // Write port from writeback, only on a retiring edge
  input  regIdx_t rfAddr,
  input  word_t   rfData,
  output logic    inReady,
  output logic    exValid,  // Execute holds a real instruction and not a bubble
  output opcode_t exOp,
  output regIdx_t exRd,
  output regIdx_t exRs1,
  output regIdx_t exRs2,
  output word_t   exImm,
  output word_t   exA,      // First operand as read from the register file
  output word_t   exB       // Second operand as read from the register file
);

  word_t       regFile [`REG_COUNT];  // Architectural registers
  issueState_t issueState;
  logic        started;  // Low for the first cycle after reset
  logic        useRs2;   // Waiting instruction reads rs2 through the ALU
  logic        loadUse;  // Waiting instruction needs the load now in execute
  logic        accept;   // Transfer on the input handshake
  word_t       readA;
  word_t       readB;

  ////////////////////////////////////////////////////////////////////
  // Load-use hazard
  ////////////////////////////////////////////////////////////////////
  // A store takes rs2 late through the memory forward, so only rs1 matters
  assign useRs2  = (inOp != opStore);
  assign loadUse = (issueState == issueRun) && inValid && exValid &&
                   (exOp == opLoad) && (exRd != '0) &&
                   ((inRs1 == exRd) || (useRs2 && (inRs2 == exRd)));

  assign inReady = started && advance && !loadUse;
  assign accept  = inValid && inReady;

  ////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////
  // Reads see a write landing on the same edge
  assign readA = (inRs1 == '0) ? '0 :
                 (rfWe && (rfAddr == inRs1)) ? rfData : regFile[inRs1];
  assign readB = (inRs2 == '0) ? '0 :
                 (rfWe && (rfAddr == inRs2)) ? rfData : regFile[inRs2];

  always_ff @(posedge clk) begin
    if (rfWe && (rfAddr != '0)) begin
      regFile[rfAddr] <= rfData;  // Register 0 keeps reading zero
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Hold FSM and execute valid
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      started    <= 1'b0;
      issueState <= issueRun;
      exValid    <= 1'b0;
    end else begin
      started <= 1'b1;
      if (advance) begin
        case (issueState)
          issueRun:  if (loadUse) issueState <= issueHold;  // Bubble goes in now
          issueHold: issueState <= issueRun;                 // Load has reached memory
          default:   issueState <= issueRun;
        endcase
        exValid <= accept;  // A missing transfer becomes a bubble
      end
    end
  end

  // Decode/execute payload, captured only on a transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      exOp  <= inOp;
      exRd  <= inRd;
      exRs1 <= inRs1;
      exRs2 <= inRs2;
      exImm <= inImm;
      exA   <= readA;
      exB   <= readB;
    end
  end

endmodule

`default_nettype wire

// File: source/ForwardingUnit.sv
`timescale 1ns/1ns
`default_nettype none

module ForwardingUnit import isaPkg::*, pipePkg::*; (
  input  regIdx_t exSrcReg1,    // First source of the instruction in execute
  input  regIdx_t exSrcReg2,    // Second source of the instruction in execute
  input  regIdx_t memSrcReg2,   // Second source of the instruction in memory, store data
  input  regIdx_t memDestReg,   // Destination of the instruction in memory
  input  regIdx_t wbDestReg,    // Destination of the instruction in writeback
  input  logic    memRegWrite,  // Memory-stage instruction writes a register
  input  logic    wbRegWrite,   // Writeback instruction writes a register
  output fwdSel_t forwardA,     // Select for the first ALU operand
  output fwdSel_t forwardB,     // Select for the second ALU operand
  output logic    forwardMem    // Replace store data with the writeback value
);

  logic memWrites;  // Memory stage produces a usable register result
  logic wbWrites;   // Writeback stage produces a usable register result
  logic memHazA;    // Memory stage result is the first operand
  logic memHazB;    // Memory stage result is the second operand
  logic wbHazA;     // Writeback result is the first operand
  logic wbHazB;     // Writeback result is the second operand

  // The youngest producer wins, so the memory stage beats writeback
  function automatic fwdSel_t pickSource(input logic fromMem, input logic fromWb);
    fwdSel_t sel;
    if (fromMem) begin
      sel = fwdFromMem;
    end else if (fromWb) begin
      sel = fwdFromWb;
    end else begin
      sel = fwdNone;
    end
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Producers
  ////////////////////////////////////////////////////////////////////
  // Register 0 is never a real destination, so it never forwards
  assign memWrites = memRegWrite && (memDestReg != '0);
  assign wbWrites  = wbRegWrite && (wbDestReg != '0);

  ////////////////////////////////////////////////////////////////////
  // Execute operand hazards
  ////////////////////////////////////////////////////////////////////
  assign memHazA = memWrites && (memDestReg == exSrcReg1);  // EX-to-EX on operand A
  assign memHazB = memWrites && (memDestReg == exSrcReg2);  // EX-to-EX on operand B
  assign wbHazA  = wbWrites && (wbDestReg == exSrcReg1);    // MEM-to-EX on operand A
  assign wbHazB  = wbWrites && (wbDestReg == exSrcReg2);    // MEM-to-EX on operand B

  assign forwardA = pickSource(memHazA, wbHazA);
  assign forwardB = pickSource(memHazB, wbHazB);

  // A load in writeback feeding the store that follows it directly
  // The store's rs2 was not held at issue, so its data is fixed here
  assign forwardMem = wbWrites && (wbDestReg == memSrcReg2);

endmodule

`default_nettype wire

// File: source/pipePkg.sv
package pipePkg;

  ////////////////////////////////////////////////////////////////////
  // Pipeline-control types
  ////////////////////////////////////////////////////////////////////

  // Source of an execute operand
  // The encoding follows the usual ForwardA/ForwardB select values
  typedef enum logic [1:0] {
    fwdNone    = 2'b00,  // Value read from the register file at issue
    fwdFromWb  = 2'b01,  // Result sitting in the writeback stage
    fwdFromMem = 2'b10   // Result sitting at the start of the memory stage
  } fwdSel_t;

  // State of the issue stage
  typedef enum logic {
    issueRun  = 1'b0,  // Instructions are accepted as they arrive
    issueHold = 1'b1   // A bubble for a load-use hazard sits in execute
  } issueState_t;

endpackage

// File: source/isaPkg.sv
`include "pipe_config.svh"

package isaPkg;

  ////////////////////////////////////////////////////////////////////
  // Instruction-set types
  ////////////////////////////////////////////////////////////////////

  // One data word as held in the register file and the data RAM
  typedef logic [`DATA_WIDTH-1:0] word_t;

  // Register index, register 0 is hardwired to zero
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

  // Operations understood by the back end
  typedef enum logic [2:0] {
    opAdd     = 3'd0,  // rd = rs1 + rs2
    opSub     = 3'd1,  // rd = rs1 - rs2
    opAnd     = 3'd2,  // rd = rs1 & rs2
    opXor     = 3'd3,  // rd = rs1 ^ rs2
    opShl     = 3'd4,  // rd = rs1 shifted left by the low bits of rs2
    opLoadImm = 3'd5,  // rd = imm
    opLoad    = 3'd6,  // rd = RAM word at rs1 + imm
    opStore   = 3'd7   // RAM word at rs1 + imm = rs2, no register write
  } opcode_t;

endpackage

// File: source/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

////////////////////////////////////////////////////////////////////
// Pipeline sizing
////////////////////////////////////////////////////////////////////

// Width of every data word, register and ALU result
`define DATA_WIDTH 16

// Number of architectural registers, register 0 reads as zero
`define REG_COUNT 16

// Number of words in the data RAM of the memory stage
`define DMEM_DEPTH 256

`endif
